/* Bender.yml */
package:
  name: sfr_block

sources:
  # design, in compile order
  - files:
      - hdl/sfr_pkg.sv
      - hdl/reg_bus_if.sv
      - hdl/ahb_reg_frontend.sv
      - hdl/sfr_control_regs.sv
      - hdl/sfr_status_flags.sv
      - hdl/sfr_block_top.sv

  # testbench, top module sfr_block_tb
  - target: test
    files:
      - bench/sfr_block_props.sv
      - bench/sfr_block_tb.sv

/* bench/sfr_block_props.sv */
// bus and pulse properties, bound into sfr_block_top; needs a simulator with concurrent assertion support
`timescale 1ns/1ps

module sfr_block_props #(
  parameter int unsigned CTRL_W = 32   // packed width of all control registers
) (
  input logic              hclk,
  input logic              hresetn,
  input logic              read_en,        // front end register bus
  input logic              write_en,
  input logic              lock,
  input logic [CTRL_W-1:0] ctrl,
  input logic              action_pulse,
  input logic              hreadyout
);

  // ------------------------------------------------------------------
  // front end
  // ------------------------------------------------------------------
  a_rd_wr_excl : assert property (@(posedge hclk) disable iff (!hresetn)
    !(read_en && write_en))
    else $error("read_en and write_en high together");

  // a locked data phase leaves every control register as it was
  a_lock_blocks_write : assert property (@(posedge hclk) disable iff (!hresetn)
    lock |=> $stable(ctrl))
    else $error("control register changed while lock is set");

  // ------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------
  a_pulse_single : assert property (@(posedge hclk) disable iff (!hresetn)
    action_pulse |=> !action_pulse)
    else $error("action_pulse lasted two cycles");

  a_always_ready : assert property (@(posedge hclk) hreadyout == 1'b1)
    else $error("hreadyout dropped");   // slave has no wait states

endmodule

bind sfr_block_top sfr_block_props #(
  .CTRL_W (CR_COUNT * sfr_pkg::SFR_W)
) u_props (
  .hclk         (hclk),
  .hresetn      (hresetn),
  .read_en      (reg_bus.read_en),
  .write_en     (reg_bus.write_en),
  .lock         (lock),
  .ctrl         (ctrl),
  .action_pulse (action_pulse),
  .hreadyout    (hreadyout)
);

/* bench/sfr_block_tb.sv */
// golden-file driven testbench; reads bench/sfr_golden.txt from the project root, default DUT parameters only
`timescale 1ns/1ps

module sfr_block_tb;
  import sfr_pkg::*;

  localparam int MAX_ROWS   = 64;
  localparam int CR_COUNT   = 2;
  localparam int FLAG_COUNT = 2;

  logic                              hclk;
  logic                              hresetn;
  logic                              hsel;
  logic [ADDR_W-1:0]                 haddr;
  logic [1:0]                        htrans;
  logic [2:0]                        hsize;
  logic                              hwrite;
  logic                              hready;
  logic [BUS_W-1:0]                  hwdata;
  logic [BUS_W-1:0]                  hrdata;
  logic                              hreadyout;
  logic                              hresp;
  logic                              lock;
  logic [FLAG_COUNT-1:0][SFR_W-1:0]  status;
  logic [FLAG_COUNT-1:0][SFR_W-1:0]  events;
  logic [CR_COUNT-1:0][SFR_W-1:0]    ctrl;
  logic [FLAG_COUNT-1:0][SFR_W-1:0]  flags;
  logic                              action_pulse;

  // golden rows, one entry per column
  logic [31:0] g_test   [MAX_ROWS];
  logic [31:0] g_op     [MAX_ROWS];   // 0 idle, 1 read, 2 write
  logic [31:0] g_addr   [MAX_ROWS];
  logic [31:0] g_size   [MAX_ROWS];
  logic [31:0] g_wdata  [MAX_ROWS];
  logic [31:0] g_lock   [MAX_ROWS];
  logic [31:0] g_status [MAX_ROWS];
  logic [31:0] g_events [MAX_ROWS];   // held for the address phase only
  logic [31:0] g_rdata  [MAX_ROWS];
  logic [31:0] g_pulse  [MAX_ROWS];

  int row_count   = 0;
  int row_idx     = 0;
  int cur_test    = -1;
  int test_count  = 0;
  int test_checks = 0;
  int test_errs   = 0;
  int check_count = 0;
  int err_count   = 0;
  int cycle_count = 0;
  int cycle_limit = 100;   // raised once the row count is known

  sfr_block_top dut (
    .hclk (hclk), .hresetn (hresetn), .hsel (hsel), .haddr (haddr), .htrans (htrans),
    .hsize (hsize), .hwrite (hwrite), .hready (hready), .hwdata (hwdata),
    .hrdata (hrdata), .hreadyout (hreadyout), .hresp (hresp), .lock (lock),
    .status (status), .events (events), .ctrl (ctrl), .flags (flags),
    .action_pulse (action_pulse)
  );

  always #50 hclk = ~hclk;   // 100 ns period

  // run limit, a few cycles per row plus reset
  always @(posedge hclk)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    check_count++;
    test_checks++;
    if (act_val !== exp_val)
    begin
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic load_golden();
    int    fd;
    string line;
    fd = $fopen("bench/sfr_golden.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the golden file bench/sfr_golden.txt");
      err_count++;
      return;
    end
    while ($fgets(line, fd) != 0 && row_count < MAX_ROWS)
    begin
      // comment lines scan zero fields and drop out here
      if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", g_test[row_count],
                  g_op[row_count], g_addr[row_count], g_size[row_count],
                  g_wdata[row_count], g_lock[row_count], g_status[row_count],
                  g_events[row_count], g_rdata[row_count], g_pulse[row_count]) == 10)
        row_count++;
    end
    $fclose(fd);
  endtask

  task automatic close_test();
    if (cur_test >= 0)
    begin
      $display("test %0d: %0d checks, %0d errors, %s", cur_test, test_checks, test_errs,
               (test_errs == 0) ? "ok" : "failed");
      test_count++;
    end
    test_checks = 0;
    test_errs   = 0;
  endtask

  // address phase, data phase, then one cycle to look for the pulse
  task automatic run_row(input int r);
    logic        is_rd;
    logic        is_wr;
    logic [31:0] a;
    is_rd  = (g_op[r] == 1);
    is_wr  = (g_op[r] == 2);
    a      = g_addr[r];
    hsel   = is_rd | is_wr;
    htrans = (is_rd | is_wr) ? HTRANS_NONSEQ : 2'b00;
    haddr  = a[ADDR_W-1:0];
    hsize  = g_size[r][2:0];
    hwrite = is_wr;
    lock   = g_lock[r][0];
    status = g_status[r];
    events = g_events[r];
    @(posedge hclk);            // edge k, address sampled
    #1;
    hsel   = 1'b0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hwdata = g_wdata[r];
    events = '0;                // one-cycle event
    while (hreadyout !== 1'b1)
      @(posedge hclk);
    @(negedge hclk);            // mid data phase, hrdata settled
    check_value("hresp", 32'h0, {31'h0, hresp});   // always OKAY
    if (is_rd)
    begin
      check_value("hrdata", g_rdata[r], hrdata);
      if (a >= CR_OFFSET && a < CR_OFFSET + 4 * CR_COUNT)
        check_value($sformatf("ctrl[%0d]", (a - CR_OFFSET) / 4), g_rdata[r],
                    {16'h0, ctrl[(a - CR_OFFSET) / 4]});
      if (a >= FR_OFFSET && a < FR_OFFSET + 4 * FLAG_COUNT)
        check_value($sformatf("flags[%0d]", (a - FR_OFFSET) / 4), g_rdata[r],
                    {16'h0, flags[(a - FR_OFFSET) / 4]});
    end
    @(posedge hclk);            // edge k+1, write lands
    #1;
    @(negedge hclk);
    check_value("action_pulse", {31'h0, g_pulse[r][0]}, {31'h0, action_pulse});
    @(posedge hclk);
    #1;
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial
  begin
    hclk    = 1'b0;
    hresetn = 1'b0;
    hsel    = 1'b0;
    haddr   = '0;
    htrans  = 2'b00;
    hsize   = HSIZE_WORD;
    hwrite  = 1'b0;
    hready  = 1'b1;   // master never stalls
    hwdata  = '0;
    lock    = 1'b0;
    status  = '0;
    events  = '0;
    load_golden();
    if (row_count == 0)
    begin
      $display("no stimulus rows were read from the golden file");
      err_count++;
    end
    cycle_limit = 4 * row_count + 100;
    repeat (5) @(posedge hclk);
    #1 hresetn = 1'b1;
    for (row_idx = 0; row_idx < row_count; row_idx++)
    begin
      if (int'(g_test[row_idx]) != cur_test)
      begin
        close_test();
        cur_test = g_test[row_idx];
      end
      run_row(row_idx);
    end
    close_test();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* bench/sfr_golden.txt */
// test op(0 idle 1 read 2 write) addr size(0 byte 1 half 2 word) wdata lock status events
// exp_rdata exp_pulse, all hex; status and events pack register 1 in the upper half
1 1 010 2 00000000 0 00000000 00000000 000000ff 0
1 1 014 2 00000000 0 00000000 00000000 000000ff 0
1 1 028 2 00000000 0 00000000 00000000 00000000 0
1 1 02c 2 00000000 0 00000000 00000000 00000000 0
1 1 030 2 00000000 0 00000000 00000000 00000000 0
2 2 010 2 deadbeef 0 00000000 00000000 00000000 0
2 1 010 2 00000000 0 00000000 00000000 0000beef 0
2 2 010 0 00005a5a 0 00000000 00000000 00000000 0
2 1 010 2 00000000 0 00000000 00000000 0000be5a 0
2 2 014 1 ffff1234 0 00000000 00000000 00000000 0
2 2 014 0 0000cdcd 0 00000000 00000000 00000000 0
2 1 014 2 00000000 0 00000000 00000000 000012cd 0
3 1 020 2 00000000 0 beef1234 00000000 00001234 0
3 1 024 2 00000000 0 beef1234 00000000 0000beef 0
3 1 020 2 00000000 0 00005555 00000000 00005555 0
4 0 000 2 00000000 0 00000000 00000005 00000000 0
4 0 000 2 00000000 0 00000000 00030000 00000000 0
4 1 028 2 00000000 0 00000000 00000000 00000005 0
4 1 02c 2 00000000 0 00000000 00000000 00000003 0
4 2 028 2 00000004 0 00000000 00000000 00000000 0
4 1 028 2 00000000 0 00000000 00000000 00000001 0
4 2 02c 0 00000201 0 00000000 00000000 00000000 0
4 1 02c 2 00000000 0 00000000 00000000 00000002 0
5 2 030 2 00000032 0 00000000 00000000 00000000 1
5 2 030 2 00000033 0 00000000 00000000 00000000 0
5 2 030 0 00000032 0 00000000 00000000 00000000 0
5 1 030 2 00000000 0 00000000 00000000 00000000 0
6 2 010 2 00001111 1 00000000 00000000 00000000 0
6 2 028 2 00000001 1 00000000 00000000 00000000 0
6 1 010 2 00000000 1 00000000 00000000 0000be5a 0
6 1 028 2 00000000 1 00000000 00000000 00000001 0

/* hdl/ahb_reg_frontend.sv */
// AHB-Lite slave capture only; always ready, no error response, sizes above a word are treated as a word
`timescale 1ns/1ps

module ahb_reg_frontend (
  input  logic                       hclk,
  input  logic                       hresetn,
  input  logic                       hsel,
  input  logic [sfr_pkg::ADDR_W-1:0] haddr,
  input  logic [1:0]                 htrans,
  input  logic [2:0]                 hsize,
  input  logic                       hwrite,
  input  logic                       hready,
  input  logic [sfr_pkg::BUS_W-1:0]  hwdata,
  input  logic                       lock,
  reg_bus_if.frontend                bus
);
  import sfr_pkg::*;

  logic                 trans_active;  // NONSEQ or SEQ on htrans
  logic                 trans_req;     // address phase accepted this edge
  logic                 rd_req;
  logic                 wr_req;
  logic                 upd_rd;        // reload read enable
  logic                 upd_wr;        // reload write enable
  logic [ADDR_W-1:0]    addr_q;
  logic                 read_en_q;
  logic                 write_en_q;
  logic [NUM_LANES-1:0] strobe_nxt;
  logic [NUM_LANES-1:0] strobe_q;

  // ------------------------------------------------------------------
  // address phase
  // ------------------------------------------------------------------
  assign trans_active = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
  assign trans_req    = hsel & hready & trans_active;
  assign rd_req       = trans_req & ~hwrite;
  assign wr_req       = trans_req &  hwrite;

  // a pending enable only drops once the data phase ends with hready
  assign upd_rd = rd_req | (read_en_q  & hready);
  assign upd_wr = wr_req | (write_en_q & hready);

  // size and low address bits select the lanes
  always_comb
  begin
    case (hsize)
      HSIZE_BYTE: strobe_nxt = NUM_LANES'(1) << haddr[1:0];     // one lane
      HSIZE_HALF: strobe_nxt = haddr[1] ? 4'b1100 : 4'b0011;    // upper or lower half
      HSIZE_WORD: strobe_nxt = '1;
      default:    strobe_nxt = '1;                              // no wider data path
    endcase
  end

  // ------------------------------------------------------------------
  // data phase registers
  // ------------------------------------------------------------------
  always_ff @(posedge hclk or negedge hresetn)
  begin
    if (!hresetn)
    begin
      read_en_q  <= 1'b0;
      write_en_q <= 1'b0;
      strobe_q   <= '0;
    end
    else
    begin
      if (upd_rd)
        read_en_q <= rd_req;
      if (upd_wr)
        write_en_q <= wr_req;
      if (upd_rd | upd_wr)
        strobe_q <= strobe_nxt;    // held while hready is low
    end
  end

  // address taken only on an accepted transfer
  always_ff @(posedge hclk)
  begin
    if (trans_req)
      addr_q <= haddr;
  end

  // ------------------------------------------------------------------
  // register bus
  // ------------------------------------------------------------------
  assign bus.addr        = addr_q;
  assign bus.read_en     = read_en_q;
  assign bus.write_en    = write_en_q & ~lock;   // lock blocks writes, reads go on
  assign bus.byte_strobe = strobe_q;
  assign bus.wdata.word  = hwdata;               // data phase word, decoded by the banks

endmodule

/* hdl/reg_bus_if.sv */
// data-phase register access, valid for one cycle per transfer; no handshake, banks must complete at once
`timescale 1ns/1ps

interface reg_bus_if;
  import sfr_pkg::*;

  logic [ADDR_W-1:0]    addr;         // registered address of the access
  logic                 read_en;      // read in data phase
  logic                 write_en;     // write in data phase, already lock gated
  logic [NUM_LANES-1:0] byte_strobe;  // lanes touched by the transfer
  sfr_word_u            wdata;        // hwdata of the data phase

  // front end drives everything
  modport frontend (
    output addr, read_en, write_en, byte_strobe, wdata
  );

  // register banks only look
  modport bank (
    input  addr, read_en, write_en, byte_strobe, wdata
  );

endinterface

/* hdl/sfr_block_top.sv */
// SFR block with a plain AHB-Lite slave port; always OKAY with no wait states, 12-bit address decode only
`timescale 1ns/1ps

module sfr_block_top #(
  parameter int unsigned               CR_COUNT   = 2,
  parameter int unsigned               FLAG_COUNT = 2,
  parameter logic [sfr_pkg::SFR_W-1:0] CR_RESET   = 16'h00ff,
  parameter logic [sfr_pkg::SFR_W-1:0] ACTION_KEY = 16'h0032
) (
  input  logic                                        hclk,
  input  logic                                        hresetn,
  // AHB-Lite slave
  input  logic                                        hsel,
  input  logic [sfr_pkg::ADDR_W-1:0]                  haddr,
  input  logic [1:0]                                  htrans,
  input  logic [2:0]                                  hsize,
  input  logic                                        hwrite,
  input  logic                                        hready,
  input  logic [sfr_pkg::BUS_W-1:0]                   hwdata,
  output logic [sfr_pkg::BUS_W-1:0]                   hrdata,
  output logic                                        hreadyout,
  output logic                                        hresp,
  // register side
  input  logic                                        lock,
  input  logic [FLAG_COUNT-1:0][sfr_pkg::SFR_W-1:0]   status,
  input  logic [FLAG_COUNT-1:0][sfr_pkg::SFR_W-1:0]   events,
  output logic [CR_COUNT-1:0][sfr_pkg::SFR_W-1:0]     ctrl,
  output logic [FLAG_COUNT-1:0][sfr_pkg::SFR_W-1:0]   flags,
  output logic                                        action_pulse
);
  import sfr_pkg::*;

  logic [BUS_W-1:0] cr_rdata;   // control bank, zero when not addressed
  logic [BUS_W-1:0] sf_rdata;   // status and flag bank

  reg_bus_if reg_bus ();

  // ------------------------------------------------------------------
  // AHB front end
  // ------------------------------------------------------------------
  ahb_reg_frontend u_frontend (
    .hclk    (hclk),
    .hresetn (hresetn),
    .hsel    (hsel),
    .haddr   (haddr),
    .htrans  (htrans),
    .hsize   (hsize),
    .hwrite  (hwrite),
    .hready  (hready),
    .hwdata  (hwdata),
    .lock    (lock),
    .bus     (reg_bus.frontend)
  );

  // ------------------------------------------------------------------
  // register banks
  // ------------------------------------------------------------------
  sfr_control_regs #(
    .CR_COUNT   (CR_COUNT),
    .CR_RESET   (CR_RESET),
    .ACTION_KEY (ACTION_KEY)
  ) u_ctrl (
    .hclk         (hclk),
    .hresetn      (hresetn),
    .bus          (reg_bus.bank),
    .ctrl         (ctrl),
    .action_pulse (action_pulse),
    .rdata        (cr_rdata)
  );

  sfr_status_flags #(
    .FLAG_COUNT (FLAG_COUNT)
  ) u_flags (
    .hclk    (hclk),
    .hresetn (hresetn),
    .bus     (reg_bus.bank),
    .status  (status),
    .events  (events),
    .flags   (flags),
    .rdata   (sf_rdata)
  );

  // banks return zero unless hit, so an OR merges them
  assign hrdata    = cr_rdata | sf_rdata;
  assign hreadyout = 1'b1;   // no wait states
  assign hresp     = 1'b0;   // always OKAY

endmodule

/* hdl/sfr_control_regs.sv */
// control bank plus keyed action register; only the low SFR_W bits exist, the key needs a full-word write
`timescale 1ns/1ps

module sfr_control_regs #(
  parameter int unsigned                CR_COUNT   = 2,
  parameter logic [sfr_pkg::SFR_W-1:0]  CR_RESET   = 16'h00ff,
  parameter logic [sfr_pkg::SFR_W-1:0]  ACTION_KEY = 16'h0032
) (
  input  logic                                      hclk,
  input  logic                                      hresetn,
  reg_bus_if.bank                                   bus,
  output logic [CR_COUNT-1:0][sfr_pkg::SFR_W-1:0]   ctrl,
  output logic                                      action_pulse,
  output logic [sfr_pkg::BUS_W-1:0]                 rdata
);
  import sfr_pkg::*;

  logic [CR_COUNT-1:0] cr_hit;     // one per control register
  logic                ar_hit;
  logic                key_write;  // full word write of the key to AR

  // ------------------------------------------------------------------
  // control registers
  // ------------------------------------------------------------------
  for (genvar i = 0; i < CR_COUNT; i++)
  begin : g_cr
    // word decode, the low address bits only pick the lane
    assign cr_hit[i] = ((bus.addr >> 2) == (ADDR_W'(CR_OFFSET + 4 * i) >> 2));

    always_ff @(posedge hclk or negedge hresetn)
    begin
      if (!hresetn)
        ctrl[i] <= CR_RESET;
      else if (bus.write_en && cr_hit[i])
      begin
        for (int l = 0; l < SFR_W / 8; l++)
        begin
          if (bus.byte_strobe[l])
            ctrl[i][l*8 +: 8] <= bus.wdata.lanes[l];  // untouched lanes keep their value
        end
      end
    end
  end

  // readback, zero above SFR_W; AR always reads 0
  always_comb
  begin
    rdata = '0;
    for (int i = 0; i < CR_COUNT; i++)
    begin
      if (bus.read_en && cr_hit[i])
        rdata = rdata | BUS_W'(ctrl[i]);
    end
  end

  // ------------------------------------------------------------------
  // action register
  // ------------------------------------------------------------------
  assign ar_hit    = ((bus.addr >> 2) == (AR_OFFSET >> 2));
  assign key_write = bus.write_en && ar_hit && (bus.byte_strobe == '1)
                     && (bus.wdata.word == BUS_W'(ACTION_KEY));

  // one cycle after the data phase; a repeated held write cannot stretch it
  always_ff @(posedge hclk or negedge hresetn)
  begin
    if (!hresetn)
      action_pulse <= 1'b0;
    else
      action_pulse <= key_write & ~action_pulse;
  end

endmodule

/* hdl/sfr_pkg.sv */
// shared widths, AHB codes and register map; only 16 bits per register are implemented, upper read bits are zero
package sfr_pkg;

  // ------------------------------------------------------------------
  // bus widths
  // ------------------------------------------------------------------
  localparam int unsigned ADDR_W    = 12;   // register address space, 4 KB
  localparam int unsigned BUS_W     = 32;   // AHB data bus
  localparam int unsigned SFR_W     = 16;   // implemented bits per register
  localparam int unsigned NUM_LANES = 4;    // byte lanes per bus word

  // AHB transfer codes, bit 1 set means an active transfer
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // transfer sizes handled by the strobe decode
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // ------------------------------------------------------------------
  // register map, bank base addresses, 4 bytes per register
  // ------------------------------------------------------------------
  localparam logic [ADDR_W-1:0] CR_OFFSET = 12'h010;  // control, read/write
  localparam logic [ADDR_W-1:0] SR_OFFSET = 12'h020;  // status, read only
  localparam logic [ADDR_W-1:0] FR_OFFSET = 12'h028;  // sticky flags, write 1 to clear
  localparam logic [ADDR_W-1:0] AR_OFFSET = 12'h030;  // action, keyed pulse

  // write data seen either as one word or as four byte lanes
  typedef union packed {
    logic [BUS_W-1:0]                word;   // key compare
    logic [NUM_LANES-1:0][7:0]       lanes;  // strobed lane writes
  } sfr_word_u;

endpackage

/* hdl/sfr_status_flags.sv */
// status readback and write-1-to-clear flags; events are sampled every edge, a clear beats an event in the same cycle
`timescale 1ns/1ps

module sfr_status_flags #(
  parameter int unsigned FLAG_COUNT = 2
) (
  input  logic                                        hclk,
  input  logic                                        hresetn,
  reg_bus_if.bank                                     bus,
  input  logic [FLAG_COUNT-1:0][sfr_pkg::SFR_W-1:0]   status,
  input  logic [FLAG_COUNT-1:0][sfr_pkg::SFR_W-1:0]   events,
  output logic [FLAG_COUNT-1:0][sfr_pkg::SFR_W-1:0]   flags,
  output logic [sfr_pkg::BUS_W-1:0]                   rdata
);
  import sfr_pkg::*;

  logic [FLAG_COUNT-1:0]             sr_hit;    // status register selected
  logic [FLAG_COUNT-1:0]             fr_hit;    // flag register selected
  logic [FLAG_COUNT-1:0][SFR_W-1:0]  clr_mask;  // bits written as 1 this cycle

  // ------------------------------------------------------------------
  // address decode and clear mask
  // ------------------------------------------------------------------
  for (genvar i = 0; i < FLAG_COUNT; i++)
  begin : g_flag
    // word decode, the low address bits only pick the lane
    assign sr_hit[i] = ((bus.addr >> 2) == (ADDR_W'(SR_OFFSET + 4 * i) >> 2));
    assign fr_hit[i] = ((bus.addr >> 2) == (ADDR_W'(FR_OFFSET + 4 * i) >> 2));

    // only strobed lanes may clear
    for (genvar l = 0; l < SFR_W / 8; l++)
    begin : g_lane
      assign clr_mask[i][l*8 +: 8] =
        (bus.write_en && fr_hit[i] && bus.byte_strobe[l]) ? bus.wdata.lanes[l] : 8'h00;
    end

    // sticky bits, set by events and cleared by software
    always_ff @(posedge hclk or negedge hresetn)
    begin
      if (!hresetn)
        flags[i] <= '0;
      else
        flags[i] <= (flags[i] | events[i]) & ~clr_mask[i];
    end
  end

  // ------------------------------------------------------------------
  // readback
  // ------------------------------------------------------------------
  always_comb
  begin
    rdata = '0;
    for (int i = 0; i < FLAG_COUNT; i++)
    begin
      if (bus.read_en && sr_hit[i])
        rdata = rdata | BUS_W'(status[i]);   // live input, not sampled
      if (bus.read_en && fr_hit[i])
        rdata = rdata | BUS_W'(flags[i]);
    end
  end

endmodule

/* src.f */
hdl/sfr_pkg.sv
hdl/reg_bus_if.sv
hdl/ahb_reg_frontend.sv
hdl/sfr_control_regs.sv
hdl/sfr_status_flags.sv
hdl/sfr_block_top.sv
bench/sfr_block_props.sv
bench/sfr_block_tb.sv
